// ==== hw/tcb_consts.svh ====
/*
  Bus and memory constants for the shared memory subsystem.
  Include this header wherever a width or the memory depth is needed.
  The include guard lets several files of one compilation unit include it.
*/

`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

// data bus width in bits
`define TCB_DW 32

// byte lanes per data word
`define TCB_BEN 4

// byte address width, covers 1 KiB
`define TCB_AW 10

// memory depth in words
`define TCB_DEPTH 256

// read data latency in cycles after the transfer
`define TCB_DLY 1

`endif

// ==== hw/tcb_pkg.sv ====
/*
  Types shared by the ports, the arbiter and the memory.
  Import into a module header where one of these types is used.
*/

`default_nettype none

`include "tcb_consts.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  // byte address and its split into word index and offset
  typedef logic [`TCB_AW-1:0]             tcb_adr_t;
  typedef logic [$clog2(`TCB_DEPTH)-1:0]  tcb_wrd_t;
  typedef logic [$clog2(`TCB_BEN)-1:0]    tcb_ofs_t;

  // data word and its lane enables
  typedef logic [`TCB_DW-1:0]             tcb_dat_t;
  typedef logic [`TCB_BEN-1:0]            tcb_ben_t;

  // log2 of transfer size, 0..2 legal
  typedef logic [1:0]                     tcb_siz_t;

  ////////////////////////////////////////////////////////////
  // arbiter state
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    ARB_LAST_P0 = 1'b0,
    ARB_LAST_P1 = 1'b1
  } arb_last_t;

endpackage

`default_nettype wire

// ==== hw/tcb_port.sv ====
/*
  Requester side of one memory port.
  Turns size and address into lane enables, steers write data onto the lanes,
  and realigns the registered memory read data into the low bytes.
  One instance per requester, placed between the requester and the arbiter.
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_port import tcb_pkg::*; (
  input  logic     tcb,
  input  logic     rst_n,
  // requester side
  input  logic     vld,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_siz_t siz,
  input  tcb_dat_t wdt,
  output logic     rdy,
  output tcb_dat_t rdt,
  // arbiter side
  output logic     req,
  output logic     req_wen,
  output tcb_wrd_t req_wrd,
  output tcb_ben_t req_ben,
  output tcb_dat_t req_wdt,
  input  logic     gnt,
  input  tcb_dat_t mem_rdt
);

  tcb_ofs_t ofs;
  logic     trn;
  // state kept for the read data cycle
  tcb_ofs_t ofs_q;
  tcb_siz_t siz_q;
  logic     rd_q;
  tcb_dat_t rdt_sh;
  tcb_dat_t rdt_msk;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // rdy mirrors the grant so a transfer is vld with grant
  assign rdy = gnt;
  assign trn = vld & gnt;

  assign req     = vld;
  assign req_wen = wen;
  assign {req_wrd, ofs} = adr;

  // lane enables from size shifted up to the offset
  always_comb begin
    case (siz)
      2'd0:    req_ben = tcb_ben_t'(4'b0001) << ofs;
      2'd1:    req_ben = tcb_ben_t'(4'b0011) << ofs;
      2'd2:    req_ben = tcb_ben_t'(4'b1111);
      default: req_ben = '0;
    endcase
  end

  // plain shift places the low bytes for aligned accesses
  assign req_wdt = wdt << {ofs, 3'b000};

  ////////////////////////////////////////////////////////////
  // read data path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= trn & ~wen;
    end
  end

  always_ff @(posedge tcb) begin
    if (trn) begin
      ofs_q <= ofs;
      siz_q <= siz;
    end
  end

  // back down to the low bytes
  assign rdt_sh = mem_rdt >> {ofs_q, 3'b000};

  // bytes above the size read as zero
  always_comb begin
    case (siz_q)
      2'd0:    rdt_msk = tcb_dat_t'(32'h0000_00ff);
      2'd1:    rdt_msk = tcb_dat_t'(32'h0000_ffff);
      default: rdt_msk = tcb_dat_t'(32'hffff_ffff);
    endcase
  end

  // mem_rdt is shared so take it only after own read
  assign rdt = rd_q ? (rdt_sh & rdt_msk) : '0;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // natural alignment
  a_align: assert property (@(posedge tcb) disable iff (!rst_n)
    vld |-> ((siz != 2'd1) || !adr[0]) && ((siz != 2'd2) || (adr[1:0] == 2'b00)));

  a_siz: assert property (@(posedge tcb) disable iff (!rst_n)
    vld |-> (siz < 2'd3));

  // requester holds its request while waiting for rdy
  a_hold: assert property (@(posedge tcb) disable iff (!rst_n)
    (vld && !rdy) |=> (vld && $stable({wen, adr, siz, wdt})));

endmodule

`default_nettype wire

// ==== hw/tcb_arbiter.sv ====
/*
  Round-robin arbiter for the two requester ports.
  Grants one request per cycle and forwards it to the memory.
  Grant is combinational from the requests, so rdy follows in the same cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_arbiter import tcb_pkg::*; (
  input  logic     tcb,
  input  logic     rst_n,
  // port 0 request
  input  logic     p0_req,
  input  logic     p0_wen,
  input  tcb_wrd_t p0_wrd,
  input  tcb_ben_t p0_ben,
  input  tcb_dat_t p0_wdt,
  output logic     p0_gnt,
  // port 1 request
  input  logic     p1_req,
  input  logic     p1_wen,
  input  tcb_wrd_t p1_wrd,
  input  tcb_ben_t p1_ben,
  input  tcb_dat_t p1_wdt,
  output logic     p1_gnt,
  // memory side
  output logic     mem_en,
  output logic     mem_we,
  output tcb_wrd_t mem_wrd,
  output tcb_ben_t mem_ben,
  output tcb_dat_t mem_wdt
);

  // port granted most recently
  arb_last_t last;

  ////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////

  // lone requester wins, on contention the other one from last time
  assign p0_gnt = p0_req & (~p1_req | (last == ARB_LAST_P1));
  assign p1_gnt = p1_req & (~p0_req | (last == ARB_LAST_P0));

  // reset value makes port 0 the favored one
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      last <= ARB_LAST_P1;
    end else if (p0_gnt) begin
      last <= ARB_LAST_P0;
    end else if (p1_gnt) begin
      last <= ARB_LAST_P1;
    end
  end

  ////////////////////////////////////////////////////////////
  // request mux
  ////////////////////////////////////////////////////////////

  assign mem_en = p0_gnt | p1_gnt;
  assign mem_we = (p0_gnt & p0_wen) | (p1_gnt & p1_wen);

  // payload from port 1 only when it holds the grant
  assign mem_wrd = p1_gnt ? p1_wrd : p0_wrd;
  assign mem_ben = p1_gnt ? p1_ben : p0_ben;
  assign mem_wdt = p1_gnt ? p1_wdt : p0_wdt;

  // one owner of the memory per cycle
  a_onehot: assert property (@(posedge tcb) disable iff (!rst_n)
    !(p0_gnt && p1_gnt));

endmodule

`default_nettype wire

// ==== hw/tcb_memory.sv ====
/*
  Single-port byte-lane RAM behind the arbiter.
  Each enabled lane is written on a write cycle.
  A read registers the addressed word, every other cycle registers zero,
  which gives the one cycle read latency seen at the ports.
*/

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_memory import tcb_pkg::*; (
  input  logic     tcb,
  input  logic     mem_en,
  input  logic     mem_we,
  input  tcb_wrd_t mem_wrd,
  input  tcb_ben_t mem_ben,
  input  tcb_dat_t mem_wdt,
  output tcb_dat_t mem_rdt
);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // one byte per lane, one word per row
  logic [`TCB_BEN-1:0][7:0] mem [0:`TCB_DEPTH-1];

  // write data viewed as lanes
  logic [`TCB_BEN-1:0][7:0] wdt_lanes;

  assign wdt_lanes = mem_wdt;

  ////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (mem_en && mem_we) begin
      for (int b = 0; b < `TCB_BEN; b++) begin
        // untouched lanes keep their byte
        if (mem_ben[b]) begin
          mem[mem_wrd][b] <= wdt_lanes[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////

  // zero on writes and idle cycles
  always_ff @(posedge tcb) begin
    if (mem_en && !mem_we) begin
      mem_rdt <= mem[mem_wrd];
    end else begin
      mem_rdt <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcb_shared_memory.sv ====
/*
  Two-port shared memory on the tightly coupled bus.
  Both requesters are peers and share one 1 KiB memory through
  a round-robin arbiter. Read data returns one cycle after the transfer.
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_shared_memory import tcb_pkg::*; (
  input  logic     tcb,
  input  logic     rst_n,
  // port 0
  input  logic     p0_vld,
  input  logic     p0_wen,
  input  tcb_adr_t p0_adr,
  input  tcb_siz_t p0_siz,
  input  tcb_dat_t p0_wdt,
  output logic     p0_rdy,
  output tcb_dat_t p0_rdt,
  // port 1
  input  logic     p1_vld,
  input  logic     p1_wen,
  input  tcb_adr_t p1_adr,
  input  tcb_siz_t p1_siz,
  input  tcb_dat_t p1_wdt,
  output logic     p1_rdy,
  output tcb_dat_t p1_rdt
);

  ////////////////////////////////////////////////////////////
  // port to arbiter
  ////////////////////////////////////////////////////////////

  logic     p0_req, p0_req_wen, p0_gnt;
  tcb_wrd_t p0_req_wrd;
  tcb_ben_t p0_req_ben;
  tcb_dat_t p0_req_wdt;

  logic     p1_req, p1_req_wen, p1_gnt;
  tcb_wrd_t p1_req_wrd;
  tcb_ben_t p1_req_ben;
  tcb_dat_t p1_req_wdt;

  // arbiter to memory, read data back to both ports
  logic     mem_en, mem_we;
  tcb_wrd_t mem_wrd;
  tcb_ben_t mem_ben;
  tcb_dat_t mem_wdt;
  tcb_dat_t mem_rdt;

  tcb_port u_port0 (
    .tcb (tcb), .rst_n (rst_n),
    .vld (p0_vld), .wen (p0_wen), .adr (p0_adr), .siz (p0_siz), .wdt (p0_wdt),
    .rdy (p0_rdy), .rdt (p0_rdt),
    .req (p0_req), .req_wen (p0_req_wen), .req_wrd (p0_req_wrd),
    .req_ben (p0_req_ben), .req_wdt (p0_req_wdt),
    .gnt (p0_gnt), .mem_rdt (mem_rdt)
  );

  tcb_port u_port1 (
    .tcb (tcb), .rst_n (rst_n),
    .vld (p1_vld), .wen (p1_wen), .adr (p1_adr), .siz (p1_siz), .wdt (p1_wdt),
    .rdy (p1_rdy), .rdt (p1_rdt),
    .req (p1_req), .req_wen (p1_req_wen), .req_wrd (p1_req_wrd),
    .req_ben (p1_req_ben), .req_wdt (p1_req_wdt),
    .gnt (p1_gnt), .mem_rdt (mem_rdt)
  );

  tcb_arbiter u_arbiter (
    .tcb (tcb), .rst_n (rst_n),
    .p0_req (p0_req), .p0_wen (p0_req_wen), .p0_wrd (p0_req_wrd),
    .p0_ben (p0_req_ben), .p0_wdt (p0_req_wdt), .p0_gnt (p0_gnt),
    .p1_req (p1_req), .p1_wen (p1_req_wen), .p1_wrd (p1_req_wrd),
    .p1_ben (p1_req_ben), .p1_wdt (p1_req_wdt), .p1_gnt (p1_gnt),
    .mem_en (mem_en), .mem_we (mem_we), .mem_wrd (mem_wrd),
    .mem_ben (mem_ben), .mem_wdt (mem_wdt)
  );

  tcb_memory u_memory (
    .tcb (tcb),
    .mem_en (mem_en), .mem_we (mem_we), .mem_wrd (mem_wrd),
    .mem_ben (mem_ben), .mem_wdt (mem_wdt), .mem_rdt (mem_rdt)
  );

endmodule

`default_nettype wire

// ==== verif/tcb_shared_memory_tb.sv ====
/*
  Testbench for the two-port shared memory.
  Drives both ports on the falling edge from an LFSR and checks rdy and rdt
  against a byte-array model and a round-robin model sampled every cycle.
*/

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_shared_memory_tb import tcb_pkg::*; ();

  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 5;
  // operation counts per phase
  localparam int FILL_OPS   = 2 * `TCB_DEPTH;
  localparam int BYTE_ITERS = 64;
  localparam int RR_OPS     = 32;
  localparam int SAME_ITERS = 4;
  localparam int MIX_OPS    = 96;
  localparam int NUM_OPS    = FILL_OPS + 3 * BYTE_ITERS + 2 * RR_OPS + 2 * SAME_ITERS
                              + 2 * MIX_OPS;
  // at most 4 cycles per operation, plus both resets
  localparam int TIMEOUT    = NUM_OPS * 4 * PERIOD + 2 * (RST_CYCLES + 1) * PERIOD;

  logic     tcb, rst_n;
  logic     p0_vld, p0_wen, p0_rdy, p1_vld, p1_wen, p1_rdy;
  tcb_adr_t p0_adr, p1_adr;
  tcb_siz_t p0_siz, p1_siz;
  tcb_dat_t p0_wdt, p0_rdt, p1_wdt, p1_rdt;

  logic [31:0] lfsr;
  int          err_cnt;
  int          trn_cnt;
  arb_last_t   rr_last;
  // reference memory, one entry per byte address
  logic [7:0]  model_mem [0:`TCB_DEPTH*`TCB_BEN-1];

  tcb_shared_memory u_tcb_shared_memory (
    .tcb (tcb), .rst_n (rst_n),
    .p0_vld (p0_vld), .p0_wen (p0_wen), .p0_adr (p0_adr), .p0_siz (p0_siz),
    .p0_wdt (p0_wdt), .p0_rdy (p0_rdy), .p0_rdt (p0_rdt),
    .p1_vld (p1_vld), .p1_wen (p1_wen), .p1_adr (p1_adr), .p1_siz (p1_siz),
    .p1_wdt (p1_wdt), .p1_rdy (p1_rdy), .p1_rdt (p1_rdt)
  );

  initial begin
    tcb = 1'b0;
    forever #(PERIOD/2) tcb = ~tcb;
  end

  ////////////////////////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////////////////////////

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic tcb_siz_t rand_siz();
    tcb_siz_t s;
    s = tcb_siz_t'(rand_bits(2));
    // 3 is illegal, fold onto word
    if (s == 2'd3) s = 2'd2;
    return s;
  endfunction

  // naturally aligned for the size
  function automatic tcb_adr_t rand_adr(input tcb_siz_t s);
    tcb_adr_t a;
    a = tcb_adr_t'(rand_bits(`TCB_AW));
    if (s == 2'd1) a[0] = 1'b0;
    else if (s == 2'd2) a[1:0] = 2'b00;
    return a;
  endfunction

  ////////////////////////////////////////////////////////////
  // error handling and reference model
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    err_cnt++;
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input tcb_dat_t got, input tcb_dat_t exp);
    assert (got === exp) else begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // writes update the model, reads return low bytes with zero above
  task automatic model_access(input logic w, input tcb_adr_t a, input tcb_siz_t s,
                              input tcb_dat_t d, output tcb_dat_t rd);
    int       n;
    tcb_adr_t ba;
    n  = (s == 2'd0) ? 1 : ((s == 2'd1) ? 2 : 4);
    rd = '0;
    for (int i = 0; i < n; i++) begin
      ba = a | tcb_adr_t'(i);
      if (w) model_mem[ba] = d[8*i +: 8];
      else rd[8*i +: 8] = model_mem[ba];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitor, samples after inputs settle and before the rising edge
  ////////////////////////////////////////////////////////////

  initial begin : monitor
    tcb_dat_t exp0, exp1;
    logic     g0, g1;
    exp0    = '0;
    exp1    = '0;
    rr_last = ARB_LAST_P1;
    forever begin
      @(negedge tcb);
      #1;
      if (!rst_n) begin
        // port 0 favored again after reset
        exp0    = '0;
        exp1    = '0;
        rr_last = ARB_LAST_P1;
      end else begin
        // rdt of the previous cycle, zero unless a read transferred
        check_val("p0_rdt", p0_rdt, exp0);
        check_val("p1_rdt", p1_rdt, exp1);
        // round robin, the port not granted last wins on contention
        if (p0_vld && p1_vld) begin
          g0 = (rr_last == ARB_LAST_P1);
          g1 = !g0;
        end else begin
          g0 = p0_vld;
          g1 = p1_vld;
        end
        check_val("p0_rdy", tcb_dat_t'(p0_rdy), tcb_dat_t'(g0));
        check_val("p1_rdy", tcb_dat_t'(p1_rdy), tcb_dat_t'(g1));
        exp0 = '0;
        exp1 = '0;
        if (g0) begin
          model_access(p0_wen, p0_adr, p0_siz, p0_wdt, exp0);
          rr_last = ARB_LAST_P0;
          trn_cnt++;
        end else if (g1) begin
          model_access(p1_wen, p1_adr, p1_siz, p1_wdt, exp1);
          rr_last = ARB_LAST_P1;
          trn_cnt++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("timeout, the run did not finish within %0d ns", TIMEOUT);
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_port(input int p, input logic v, input logic w, input tcb_adr_t a,
                            input tcb_siz_t s, input tcb_dat_t d);
    if (p == 0) begin
      p0_vld = v;
      p0_wen = w;
      p0_adr = a;
      p0_siz = s;
      p0_wdt = d;
    end else begin
      p1_vld = v;
      p1_wen = w;
      p1_adr = a;
      p1_siz = s;
      p1_wdt = d;
    end
  endtask

  // present a request and hold it until rdy, vld stays high afterwards
  task automatic issue(input int p, input logic w, input tcb_adr_t a, input tcb_siz_t s,
                       input tcb_dat_t d);
    logic done;
    @(negedge tcb);
    drive_port(p, 1'b1, w, a, s, d);
    done = 1'b0;
    while (!done) begin
      #1;
      done = (p == 0) ? p0_rdy : p1_rdy;
      if (!done) @(negedge tcb);
    end
  endtask

  task automatic idle(input int p);
    @(negedge tcb);
    drive_port(p, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic apply_reset();
    @(negedge tcb);
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(negedge tcb);
    rst_n = 1'b1;
  endtask

  // write, read back at the same size, then the whole word from the other port
  task automatic sized_check();
    int       p;
    tcb_siz_t s;
    tcb_adr_t a;
    p = int'(rand_bits(1));
    s = rand_siz();
    a = rand_adr(s);
    issue(p, 1'b1, a, s, rand_bits(32));
    issue(p, 1'b0, a, s, '0);
    idle(p);
    issue(1 - p, 1'b0, {a[`TCB_AW-1:2], 2'b00}, 2'd2, '0);
    idle(1 - p);
  endtask

  // back to back requests, vld never drops in between
  task automatic random_traffic(input int p, input int n, input logic gaps);
    tcb_siz_t s;
    logic     w;
    for (int i = 0; i < n; i++) begin
      if (gaps && (rand_bits(1) != 0)) idle(p);
      s = rand_siz();
      w = (rand_bits(1) != 0);
      issue(p, w, rand_adr(s), s, rand_bits(32));
    end
    idle(p);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    tcb_adr_t a;
    rst_n   = 1'b0;
    err_cnt = 0;
    trn_cnt = 0;
    lfsr    = 32'hdd5421b9;
    drive_port(0, 1'b0, 1'b0, '0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0, '0);
    for (int i = 0; i < `TCB_DEPTH*`TCB_BEN; i++) model_mem[i] = '0;
    apply_reset();

    // fill through port 0, read back through port 1
    for (int i = 0; i < `TCB_DEPTH; i++) begin
      issue(0, 1'b1, tcb_adr_t'({i[7:0], 2'b00}), 2'd2, rand_bits(32));
    end
    idle(0);
    for (int i = 0; i < `TCB_DEPTH; i++) begin
      issue(1, 1'b0, tcb_adr_t'({i[7:0], 2'b00}), 2'd2, '0);
    end
    idle(1);

    // byte and halfword lanes
    for (int i = 0; i < BYTE_ITERS; i++) sized_check();

    // contention from reset, grants must alternate starting at port 0
    apply_reset();
    fork
      random_traffic(0, RR_OPS, 1'b0);
      random_traffic(1, RR_OPS, 1'b0);
    join

    // write and read of one word requested in the same cycle
    for (int i = 0; i < SAME_ITERS; i++) begin
      a = rand_adr(2'd2);
      fork
        begin
          issue(0, 1'b1, a, 2'd2, rand_bits(32));
          idle(0);
        end
        begin
          issue(1, 1'b0, a, 2'd2, '0);
          idle(1);
        end
      join
    end

    // mixed traffic with random idle cycles
    fork
      random_traffic(0, MIX_OPS, 1'b1);
      random_traffic(1, MIX_OPS, 1'b1);
    join

    repeat (3) @(negedge tcb);
    $display("%0d transfers checked", trn_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/tcb_pkg.sv
hw/tcb_port.sv
hw/tcb_arbiter.sv
hw/tcb_memory.sv
hw/tcb_shared_memory.sv
verif/tcb_shared_memory_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the shared memory testbench with Verilator and run it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tcb_shared_memory_tb --Mdir obj_dir -o tcb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tcb_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "all tests passed" sim.log || { echo "no result in log"; exit 1; }
exit 0
